// File: hdl/sig_verify_pkg.sv
`default_nettype none

package sig_verify_pkg;

  localparam int WORD_BITS = 64;
  localparam int LIMBS = 4;
  // Header, index, four s limbs and four r limbs
  localparam int CMD_WORDS = 10;
  localparam int RPL_WORDS = 6;
  localparam int RPL_BYTES = RPL_WORDS * WORD_BITS / 8;

  // Cycles between job start and the inverse result
  localparam int TIMEOUT_CYCLES = 1024;

  localparam logic [15:0] CMD_VERIFY_SIG = 16'h0100;
  localparam logic [15:0] CMD_VERIFY_SIG_RPL = 16'h8100;

  typedef logic [LIMBS*WORD_BITS-1:0] scalar_t;

  // secp256k1 group order and field prime
  localparam scalar_t CURVE_N =
    256'hFFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFE_BAAEDCE6_AF48A03B_BFD25E8C_D0364141;
  localparam scalar_t CURVE_P =
    256'hFFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFE_FFFFFC2F;

  typedef struct packed {
    logic [2:0] spare;
    logic       timeout_fail;
    logic       r_plus_n_lt_p;
    logic       r_zero;
    logic       r_out_of_range;
    logic       s_out_of_range;
  } sig_status_t;

  // Command code sits in the low bits of the first word
  typedef struct packed {
    logic [23:0] spare;
    sig_status_t status;
    logic [15:0] len;
    logic [15:0] cmd;
  } header_t;

  typedef union packed {
    header_t              hdr;
    logic [WORD_BITS-1:0] data;
  } cmd_word_t;

  typedef struct packed {
    cmd_word_t dat;
    logic      sop;
    logic      eop;
  } stream_word_t;

  typedef struct packed {
    logic [WORD_BITS-1:0] index;
    scalar_t              s;
    scalar_t              r;
  } sig_job_t;

endpackage

`default_nettype wire

// File: hdl/sig_cmd_parser.sv
`timescale 1ns/1ps
`default_nettype none

module sig_cmd_parser (
  input  wire                          i_clk,
  input  wire                          i_rst,
  input  wire sig_verify_pkg::stream_word_t i_rx,
  input  wire                          i_rx_val,
  input  wire                          i_reply_done,
  output logic                         o_rx_rdy,
  output sig_verify_pkg::sig_job_t     o_job,
  output logic                         o_job_start
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_INDEX,
    ST_LIMBS,
    ST_WAIT_RPL,
    ST_DRAIN
  } state_t;

  state_t     state;
  logic [2:0] limb_cnt;
  logic       rx_fire;

  // Only one job in flight, so input stalls until the reply has gone out
  assign o_rx_rdy = (state != ST_WAIT_RPL);
  assign rx_fire = i_rx_val && o_rx_rdy;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state <= ST_IDLE;
      limb_cnt <= '0;
      o_job_start <= 1'b0;
    end else begin
      o_job_start <= 1'b0;
      case (state)
        ST_IDLE: begin
          limb_cnt <= '0;
          if (rx_fire) begin
            if (i_rx.dat.hdr.cmd == sig_verify_pkg::CMD_VERIFY_SIG) begin
              state <= ST_INDEX;
            end else if (!i_rx.eop) begin
              // Unknown command, swallow the rest of it
              state <= ST_DRAIN;
            end
          end
        end
        ST_INDEX: begin
          if (rx_fire) begin
            state <= ST_LIMBS;
          end
        end
        ST_LIMBS: begin
          if (rx_fire) begin
            limb_cnt <= limb_cnt + 3'd1;
            if (limb_cnt == 3'(sig_verify_pkg::CMD_WORDS - 3)) begin
              state <= ST_WAIT_RPL;
              o_job_start <= 1'b1;
            end
          end
        end
        ST_WAIT_RPL: begin
          if (i_reply_done) begin
            state <= ST_IDLE;
          end
        end
        ST_DRAIN: begin
          if (rx_fire && i_rx.eop) begin
            state <= ST_IDLE;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // Job fields, s limbs first then r limbs, low limb first
  always_ff @(posedge i_clk) begin
    if (rx_fire && state == ST_INDEX) begin
      o_job.index <= i_rx.dat.data;
    end
    if (rx_fire && state == ST_LIMBS) begin
      if (limb_cnt < sig_verify_pkg::LIMBS) begin
        o_job.s[limb_cnt[1:0]*sig_verify_pkg::WORD_BITS +: sig_verify_pkg::WORD_BITS] <=
          i_rx.dat.data;
      end else begin
        o_job.r[limb_cnt[1:0]*sig_verify_pkg::WORD_BITS +: sig_verify_pkg::WORD_BITS] <=
          i_rx.dat.data;
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/scalar_inverse.sv
`timescale 1ns/1ps
`default_nettype none

module scalar_inverse (
  input  wire                          i_clk,
  input  wire                          i_rst,
  input  wire sig_verify_pkg::scalar_t i_s,
  input  wire                          i_start,
  input  wire                          i_abort,
  output sig_verify_pkg::scalar_t      o_w,
  output logic                         o_done
);

  logic                    busy;
  sig_verify_pkg::scalar_t u;
  sig_verify_pkg::scalar_t v;
  sig_verify_pkg::scalar_t x1;
  sig_verify_pkg::scalar_t x2;

  // x/2 mod n, adding n first when x is odd
  function automatic sig_verify_pkg::scalar_t half_mod_n(input sig_verify_pkg::scalar_t x);
    logic [256:0] sum;
    sum = {1'b0, x};
    if (x[0]) begin
      sum = sum + {1'b0, sig_verify_pkg::CURVE_N};
    end
    return sum[256:1];
  endfunction

  // (a - b) mod n for a, b already below n
  function automatic sig_verify_pkg::scalar_t sub_mod_n(input sig_verify_pkg::scalar_t a,
                                                        input sig_verify_pkg::scalar_t b);
    logic [256:0] diff;
    diff = {1'b0, a} - {1'b0, b};
    if (diff[256]) begin
      diff = diff + {1'b0, sig_verify_pkg::CURVE_N};
    end
    return diff[255:0];
  endfunction

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      busy <= 1'b0;
      o_done <= 1'b0;
    end else begin
      o_done <= 1'b0;
      if (i_abort) begin
        busy <= 1'b0;
      end else if (i_start) begin
        busy <= 1'b1;
      end else if (busy && (u == 256'd1 || v == 256'd1)) begin
        busy <= 1'b0;
        o_done <= 1'b1;
      end
    end
  end

  // Invariants x1*s = u and x2*s = v (mod n)
  // Every step halves u or v, so at most 512 steps for s coprime to n
  always_ff @(posedge i_clk) begin
    if (i_abort) begin
      o_w <= '0;
    end else if (i_start) begin
      u <= i_s;
      v <= sig_verify_pkg::CURVE_N;
      x1 <= 256'd1;
      x2 <= '0;
      o_w <= '0;
    end else if (busy) begin
      if (u == 256'd1) begin
        o_w <= x1;
      end else if (v == 256'd1) begin
        o_w <= x2;
      end else if (!u[0]) begin
        u <= u >> 1;
        x1 <= half_mod_n(x1);
      end else if (!v[0]) begin
        v <= v >> 1;
        x2 <= half_mod_n(x2);
      end else if (u >= v) begin
        // Both odd, difference is even and gets halved right away
        u <= (u - v) >> 1;
        x1 <= half_mod_n(sub_mod_n(x1, x2));
      end else begin
        v <= (v - u) >> 1;
        x2 <= half_mod_n(sub_mod_n(x2, x1));
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/sig_status_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module sig_status_tracker (
  input  wire                           i_clk,
  input  wire                           i_rst,
  input  wire sig_verify_pkg::sig_job_t i_job,
  input  wire                           i_job_start,
  input  wire                           i_inv_done,
  output sig_verify_pkg::sig_status_t   o_status,
  output logic                          o_status_final,
  output logic                          o_inv_abort
);

  logic [256:0] r_plus_n;
  logic         s_ge_n;
  logic         r_ge_n;
  logic         r_is_zero;
  logic         stage1_val;
  logic         busy;
  logic [$clog2(sig_verify_pkg::TIMEOUT_CYCLES)-1:0] timer;

  // First stage, r+n kept at full width so it cannot wrap
  always_ff @(posedge i_clk) begin
    if (i_job_start) begin
      r_plus_n <= {1'b0, i_job.r} + {1'b0, sig_verify_pkg::CURVE_N};
      s_ge_n <= (i_job.s >= sig_verify_pkg::CURVE_N);
      r_ge_n <= (i_job.r >= sig_verify_pkg::CURVE_N);
      r_is_zero <= (i_job.r == '0);
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      stage1_val <= 1'b0;
      busy <= 1'b0;
      timer <= '0;
      o_status <= '0;
      o_status_final <= 1'b0;
      o_inv_abort <= 1'b0;
    end else begin
      stage1_val <= i_job_start;
      o_status_final <= 1'b0;
      o_inv_abort <= 1'b0;

      if (i_job_start) begin
        o_status <= '0;
        busy <= 1'b1;
        timer <= '0;
      end else if (busy) begin
        if (i_inv_done) begin
          busy <= 1'b0;
          o_status_final <= 1'b1;
        end else if (timer == sig_verify_pkg::TIMEOUT_CYCLES - 1) begin
          // Inverse never settles, stop it and report
          busy <= 1'b0;
          o_status.timeout_fail <= 1'b1;
          o_status_final <= 1'b1;
          o_inv_abort <= 1'b1;
        end else begin
          timer <= timer + 1'b1;
        end
      end

      // Second stage of the range checks
      if (stage1_val) begin
        o_status.s_out_of_range <= s_ge_n;
        o_status.r_out_of_range <= r_ge_n;
        o_status.r_zero <= r_is_zero;
        o_status.r_plus_n_lt_p <= (r_plus_n < {1'b0, sig_verify_pkg::CURVE_P});
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/sig_reply_builder.sv
`timescale 1ns/1ps
`default_nettype none

module sig_reply_builder (
  input  wire                              i_clk,
  input  wire                              i_rst,
  input  wire [sig_verify_pkg::WORD_BITS-1:0] i_index,
  input  wire sig_verify_pkg::scalar_t     i_w,
  input  wire sig_verify_pkg::sig_status_t i_status,
  input  wire                              i_status_final,
  input  wire                              i_tx_rdy,
  output sig_verify_pkg::stream_word_t     o_tx,
  output logic                             o_tx_val,
  output logic                             o_reply_done
);

  logic [sig_verify_pkg::RPL_WORDS*sig_verify_pkg::WORD_BITS-1:0] rpl_sreg;
  logic [2:0]                  word_cnt;
  logic                        tx_fire;
  sig_verify_pkg::header_t     rpl_hdr;

  always_comb begin
    rpl_hdr = '0;
    rpl_hdr.cmd = sig_verify_pkg::CMD_VERIFY_SIG_RPL;
    rpl_hdr.len = 16'(sig_verify_pkg::RPL_BYTES);
    rpl_hdr.status = i_status;
  end

  assign tx_fire = o_tx_val && i_tx_rdy;

  // Current word is always the low slice of the shift register
  assign o_tx = {rpl_sreg[sig_verify_pkg::WORD_BITS-1:0],
                 word_cnt == 3'd0,
                 word_cnt == 3'(sig_verify_pkg::RPL_WORDS - 1)};

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_tx_val <= 1'b0;
      o_reply_done <= 1'b0;
      word_cnt <= '0;
    end else begin
      o_reply_done <= 1'b0;
      if (i_status_final) begin
        o_tx_val <= 1'b1;
        word_cnt <= '0;
      end else if (tx_fire) begin
        word_cnt <= word_cnt + 3'd1;
        if (word_cnt == 3'(sig_verify_pkg::RPL_WORDS - 1)) begin
          o_tx_val <= 1'b0;
          o_reply_done <= 1'b1;
          word_cnt <= '0;
        end
      end
    end
  end

  // Header, index, then w low limb first
  always_ff @(posedge i_clk) begin
    if (i_status_final) begin
      rpl_sreg <= {i_w, i_index, rpl_hdr};
    end else if (tx_fire) begin
      rpl_sreg <= rpl_sreg >> sig_verify_pkg::WORD_BITS;
    end
  end

endmodule

`default_nettype wire

// File: hdl/sig_verify_top.sv
`timescale 1ns/1ps
`default_nettype none

module sig_verify_top (
  input  wire                               i_clk,
  input  wire                               i_rst,
  input  wire sig_verify_pkg::stream_word_t i_rx,
  input  wire                               i_rx_val,
  output logic                              o_rx_rdy,
  output sig_verify_pkg::stream_word_t      o_tx,
  output logic                              o_tx_val,
  input  wire                               i_tx_rdy
);

  sig_verify_pkg::sig_job_t    job;
  logic                        job_start;
  sig_verify_pkg::scalar_t     inv_w;
  logic                        inv_done;
  logic                        inv_abort;
  sig_verify_pkg::sig_status_t status;
  logic                        status_final;
  logic                        reply_done;

  sig_cmd_parser i_sig_cmd_parser (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_rx         (i_rx),
    .i_rx_val     (i_rx_val),
    .i_reply_done (reply_done),
    .o_rx_rdy     (o_rx_rdy),
    .o_job        (job),
    .o_job_start  (job_start)
  );

  // s inverse mod n, runs alongside the range checks
  scalar_inverse i_scalar_inverse (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_s     (job.s),
    .i_start (job_start),
    .i_abort (inv_abort),
    .o_w     (inv_w),
    .o_done  (inv_done)
  );

  sig_status_tracker i_sig_status_tracker (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_job          (job),
    .i_job_start    (job_start),
    .i_inv_done     (inv_done),
    .o_status       (status),
    .o_status_final (status_final),
    .o_inv_abort    (inv_abort)
  );

  sig_reply_builder i_sig_reply_builder (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_index        (job.index),
    .i_w            (inv_w),
    .i_status       (status),
    .i_status_final (status_final),
    .i_tx_rdy       (i_tx_rdy),
    .o_tx           (o_tx),
    .o_tx_val       (o_tx_val),
    .o_reply_done   (reply_done)
  );

endmodule

`default_nettype wire

// File: include/tb_sig_verify_checks.svh
`ifndef TB_SIG_VERIFY_CHECKS_SVH
`define TB_SIG_VERIFY_CHECKS_SVH

  // Full 512-bit product reduced by the group order
  function automatic sig_verify_pkg::scalar_t mul_mod_n(input sig_verify_pkg::scalar_t a,
                                                        input sig_verify_pkg::scalar_t b);
    logic [511:0] prod;
    prod = {256'd0, a} * {256'd0, b};
    return 256'(prod % {256'd0, sig_verify_pkg::CURVE_N});
  endfunction

  // 257-bit sum, no wrap
  function automatic logic [256:0] add_wide(input sig_verify_pkg::scalar_t a,
                                            input sig_verify_pkg::scalar_t b);
    return {1'b0, a} + {1'b0, b};
  endfunction

  task automatic check_header(input string name, input sig_verify_pkg::header_t got,
                              input sig_verify_pkg::header_t exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_index(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_scalar(input string name, input sig_verify_pkg::scalar_t got,
                              input sig_verify_pkg::scalar_t exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("** Error at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

`endif

// File: test/tb_sig_verify.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sig_verify;

  localparam int NUM_ENTRIES = 9;
  localparam int CYCLE_LIMIT = NUM_ENTRIES * 1200 + 100;

  typedef struct packed {
    logic [15:0]             cmd;
    logic [63:0]             index;
    sig_verify_pkg::scalar_t s;
    sig_verify_pkg::scalar_t r;
    logic                    expect_reply;
  } entry_t;

  logic                         i_clk;
  logic                         i_rst;
  sig_verify_pkg::stream_word_t i_rx;
  logic                         i_rx_val;
  logic                         o_rx_rdy;
  sig_verify_pkg::stream_word_t o_tx;
  logic                         o_tx_val;
  logic                         i_tx_rdy;

  entry_t                       entries [NUM_ENTRIES];
  sig_verify_pkg::stream_word_t rpl_q [$];
  integer                       seed = 32'h26e2;
  int                           err_count = 0;
  int                           check_count = 0;
  int                           cycles;

  `include "tb_sig_verify_checks.svh"

  sig_verify_top i_sig_verify_top (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_rx     (i_rx),
    .i_rx_val (i_rx_val),
    .o_rx_rdy (o_rx_rdy),
    .o_tx     (o_tx),
    .o_tx_val (o_tx_val),
    .i_tx_rdy (i_tx_rdy)
  );

  initial begin
    i_clk = 1'b0;
    forever #10 i_clk = ~i_clk;
  end

  // Expected status flags
  // An s that is a multiple of n has no inverse and times out
  function automatic sig_verify_pkg::sig_status_t expected_status(
      input sig_verify_pkg::scalar_t s, input sig_verify_pkg::scalar_t r);
    sig_verify_pkg::sig_status_t st;
    st = '0;
    st.s_out_of_range = (s >= sig_verify_pkg::CURVE_N);
    st.r_out_of_range = (r >= sig_verify_pkg::CURVE_N);
    st.r_zero = (r == '0);
    st.r_plus_n_lt_p = (add_wide(r, sig_verify_pkg::CURVE_N) < {1'b0, sig_verify_pkg::CURVE_P});
    st.timeout_fail = ((s % sig_verify_pkg::CURVE_N) == '0);
    return st;
  endfunction

  task automatic load_entries();
    entries[0] = {sig_verify_pkg::CMD_VERIFY_SIG, 64'h0000_0000_0000_0011,
                  256'h1234_5678_9ABC_DEF0_0FED_CBA9_8765_4321, 256'h3, 1'b1};
    entries[1] = {sig_verify_pkg::CMD_VERIFY_SIG, 64'hA5A5_0000_0000_0002,
                  sig_verify_pkg::CURVE_N - 256'd2, sig_verify_pkg::CURVE_N - 256'd1, 1'b1};
    entries[2] = {sig_verify_pkg::CMD_VERIFY_SIG, 64'h0000_0000_0000_0003,
                  sig_verify_pkg::CURVE_N + 256'd7, 256'h77, 1'b1};
    entries[3] = {sig_verify_pkg::CMD_VERIFY_SIG, 64'h0000_0000_0000_0004,
                  256'hDEAD_BEEF, sig_verify_pkg::CURVE_N + 256'h100, 1'b1};
    entries[4] = {sig_verify_pkg::CMD_VERIFY_SIG, 64'h0000_0000_0000_0005,
                  256'd3, 256'd0, 1'b1};
    entries[5] = {sig_verify_pkg::CMD_VERIFY_SIG, 64'h0000_0000_0000_0006,
                  256'd0, 256'h5, 1'b1};
    // Unknown code is drained with no reply
    entries[6] = {16'h0300, 64'h0000_0000_0000_0BAD, 256'h99, 256'h42, 1'b0};
    entries[7] = {sig_verify_pkg::CMD_VERIFY_SIG, 64'hC0DE_0000_0000_0007,
                  256'hC0FFEE_0000_1111_2222_3333_4444_5555_6666_7777, 256'd1, 1'b1};
    entries[8] = {sig_verify_pkg::CMD_VERIFY_SIG, 64'h0000_0000_0000_0008,
                  sig_verify_pkg::CURVE_N, sig_verify_pkg::CURVE_N - 256'd1, 1'b1};
  endtask

  // Called 1 ns after a rising edge and returns 1 ns after the handshake edge
  task automatic send_word(input logic [63:0] data, input logic sop, input logic eop);
    i_rx.dat.data = data;
    i_rx.sop = sop;
    i_rx.eop = eop;
    i_rx_val = 1'b1;
    while (!o_rx_rdy) begin
      @(posedge i_clk);
      #1;
    end
    @(posedge i_clk);
    #1;
  endtask

  task automatic send_command(input entry_t e);
    logic [63:0]             words [sig_verify_pkg::CMD_WORDS];
    sig_verify_pkg::header_t hdr;
    hdr = '0;
    hdr.cmd = e.cmd;
    hdr.len = 16'(sig_verify_pkg::CMD_WORDS * 8);
    words[0] = hdr;
    words[1] = e.index;
    for (int k = 0; k < sig_verify_pkg::LIMBS; k++) begin
      words[2 + k] = e.s[k*sig_verify_pkg::WORD_BITS +: sig_verify_pkg::WORD_BITS];
      words[6 + k] = e.r[k*sig_verify_pkg::WORD_BITS +: sig_verify_pkg::WORD_BITS];
    end
    @(posedge i_clk);
    #1;
    for (int k = 0; k < sig_verify_pkg::CMD_WORDS; k++) begin
      send_word(words[k], k == 0, k == sig_verify_pkg::CMD_WORDS - 1);
    end
    i_rx_val = 1'b0;
  endtask

  task automatic check_reply(input entry_t e);
    sig_verify_pkg::stream_word_t words [sig_verify_pkg::RPL_WORDS];
    sig_verify_pkg::header_t      exp_hdr;
    sig_verify_pkg::scalar_t      got_w;
    exp_hdr = '0;
    exp_hdr.cmd = sig_verify_pkg::CMD_VERIFY_SIG_RPL;
    exp_hdr.len = 16'(sig_verify_pkg::RPL_BYTES);
    exp_hdr.status = expected_status(e.s, e.r);
    for (int k = 0; k < sig_verify_pkg::RPL_WORDS; k++) begin
      words[k] = rpl_q.pop_front();
      check_flag($sformatf("o_tx.sop word %0d", k), words[k].sop, k == 0);
      check_flag($sformatf("o_tx.eop word %0d", k), words[k].eop,
                 k == sig_verify_pkg::RPL_WORDS - 1);
    end
    got_w = {words[5].dat.data, words[4].dat.data, words[3].dat.data, words[2].dat.data};
    check_header("o_tx header", words[0].dat.hdr, exp_hdr);
    check_index("o_tx index", words[1].dat.data, e.index);
    if (exp_hdr.status.timeout_fail) begin
      check_scalar("o_tx w", got_w, '0);
    end else begin
      check_scalar("s*w mod n", mul_mod_n(e.s, got_w), 256'd1);
    end
  endtask

  // Random back-pressure on the reply stream
  initial begin
    forever begin
      @(posedge i_clk);
      #1;
      i_tx_rdy = (($random(seed) & 3) != 0);
    end
  end

  // Reply words are captured mid-cycle where val, rdy and data are settled
  initial begin
    forever begin
      @(negedge i_clk);
      if (!i_rst && o_tx_val && i_tx_rdy) begin
        rpl_q.push_back(o_tx);
      end
    end
  end

  initial begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge i_clk);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    i_rst = 1'b1;
    i_rx = '0;
    i_rx_val = 1'b0;
    i_tx_rdy = 1'b0;
    load_entries();
    repeat (10) @(posedge i_clk);
    #1;
    i_rst = 1'b0;
    // Idle after reset
    check_flag("o_rx_rdy", o_rx_rdy, 1'b1);
    check_flag("o_tx_val", o_tx_val, 1'b0);
    for (int n = 0; n < NUM_ENTRIES; n++) begin
      send_command(entries[n]);
      // A verify job blocks the input, a drained command leaves it open
      check_flag("o_rx_rdy", o_rx_rdy, !entries[n].expect_reply);
      if (entries[n].expect_reply) begin
        while (rpl_q.size() < sig_verify_pkg::RPL_WORDS) begin
          @(posedge i_clk);
        end
        check_reply(entries[n]);
      end
    end
    // Parser idle again means the last reply has fully gone out
    @(posedge i_clk);
    #1;
    while (!o_rx_rdy) begin
      @(posedge i_clk);
      #1;
    end
    check_flag("o_tx_val", o_tx_val, 1'b0);
    if (rpl_q.size() != 0) begin
      err_count++;
      $display("Unexpected reply words: %0d left over after the last reply", rpl_q.size());
    end
    $display("Checks: %0d, errors: %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+include
hdl/sig_verify_pkg.sv
hdl/sig_cmd_parser.sv
hdl/scalar_inverse.sv
hdl/sig_status_tracker.sv
hdl/sig_reply_builder.sv
hdl/sig_verify_top.sv
test/tb_sig_verify.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing -Wno-fatal -f filelist.f --top-module tb_sig_verify \
  -Mdir "$OBJ" -o tb_sig_verify
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ/tb_sig_verify" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q '^\*\*\* TEST PASSED \*\*\*$' "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
